//--- source/flow_deser_pkg.sv
/*
  Shared sizes and flit types for the packet flit deserializer.
  Every module in the design refers to these by scoped names, so the
  push and pop widths, the slice ratio and the slice order are all
  changed here and nowhere else.
*/

package flow_deser_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // Width of one narrow flit on the push side
  localparam int push_width = 8;

  // Width of one wide word on the pop side
  localparam int pop_width = 32;

  // Sideband metadata carried next to the data, never serialized
  localparam int metadata_width = 3;

  // Number of push flits that fill one pop word
  localparam int deser_ratio = pop_width / push_width;

  // Enough bits to name every slice of a pop word
  localparam int flit_id_width = $clog2(deser_ratio);

  // Slice order of the pop word
  // 0 puts the first flit of a word into the least-significant slice,
  // 1 puts it into the most-significant slice
  localparam bit deserialize_msb_first = 1'b0;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  // Index of a slice inside the word being built
  typedef logic [flit_id_width-1:0] flit_id_t;

  // One flit as presented on the push side
  typedef struct packed {
    logic [push_width-1:0]     data;
    logic                      last;
    logic [metadata_width-1:0] metadata;
  } push_flit_t;

  // One assembled word as presented on the pop side
  // The don't-care count only means something when last is set
  typedef struct packed {
    logic [pop_width-1:0]      data;
    logic                      last;
    flit_id_t                  dont_care_count;
    logic [metadata_width-1:0] metadata;
  } pop_flit_t;

endpackage

//--- source/flit_sequencer.sv
/*
  Control path of the flit deserializer.
  Tracks which slice of the current pop word the next push flit fills,
  decides when a flit completes the word, and generates both sides of
  the ready/valid handshake plus the load enables for the slice store.
  All outputs are combinational from the inputs and the slice index.
*/

`timescale 1ns/1ps

module flit_sequencer (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    push_valid,
  input  logic                                    push_last,
  input  logic                                    pop_ready,
  output logic                                    push_ready,
  output logic                                    pop_valid,
  output flow_deser_pkg::flit_id_t                flit_id,
  output logic [flow_deser_pkg::deser_ratio-2:0]  slice_load
);

  // Index of the final slice, where a word always completes
  localparam flow_deser_pkg::flit_id_t last_index =
    flow_deser_pkg::flit_id_t'(flow_deser_pkg::deser_ratio - 1);

  logic at_last_index;
  logic word_done;
  logic push_fire;
  logic pop_fire;
  logic store_en;

  // --------------------------------------------------
  // Word completion and handshakes
  // --------------------------------------------------

  assign at_last_index = (flit_id == last_index);

  // A valid flit finishes the word when it lands in the final slice
  // or when the packet ends early with last set
  assign word_done = push_valid && (at_last_index || push_last);

  // The completing flit goes straight through to the pop side, so the
  // pop word is valid in the same cycle as that flit
  assign pop_valid = word_done;

  // Flits that only fill a register are always taken
  // A completing flit must wait until the pop side accepts the word
  assign push_ready = !word_done || pop_ready;

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // Only non-completing flits need to be kept for a later cycle
  assign store_en = push_fire && !word_done;

  // --------------------------------------------------
  // Slice load enables
  // --------------------------------------------------

  // One enable per stored slice, raised only for the slice at the
  // current index, so untouched registers do not toggle
  for (genvar i = 0; i < flow_deser_pkg::deser_ratio - 1; i++) begin : gen_load
    assign slice_load[i] = store_en && (flit_id == flow_deser_pkg::flit_id_t'(i));
  end

  // --------------------------------------------------
  // Slice index counter
  // --------------------------------------------------

  // A pop transfer restarts the word at slice 0
  // A stored flit moves the index on by one
  // Under back-pressure neither happens and the index holds
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flit_id <= '0;
    end else if (pop_fire) begin
      flit_id <= '0;
    end else if (store_en) begin
      flit_id <= flit_id + 1'b1;
    end
  end

endmodule

//--- source/slice_store.sv
/*
  Holding registers for the slices of the pop word under construction.
  Only the non-final slices are stored; the final slice of a word is
  always taken live from the push side. Each register has its own load
  enable and keeps its value until that enable fires again.
*/

`timescale 1ns/1ps

module slice_store (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [flow_deser_pkg::deser_ratio-2:0]
                                              slice_load,
  input  logic [flow_deser_pkg::push_width-1:0]
                                              slice_data,
  output logic [flow_deser_pkg::deser_ratio-2:0][flow_deser_pkg::push_width-1:0]
                                              slices
);

  // --------------------------------------------------
  // One register per stored slice
  // --------------------------------------------------

  // The incoming flit data is fanned out to every register, and the
  // load enable picks which one captures it
  // This avoids shifting the whole word on every accepted flit
  for (genvar i = 0; i < flow_deser_pkg::deser_ratio - 1; i++) begin : gen_slice

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        slices[i] <= '0;
      end else if (slice_load[i]) begin
        slices[i] <= slice_data;
      end
    end

  end

endmodule

//--- source/flit_assembler.sv
/*
  Combinational pop word builder.
  Merges the stored slices with the live push flit into one pop word,
  zero-fills the slices that a short last word never reached, places
  the slices in the configured order and derives the don't-care count.
  Metadata and the last flag are taken from the live flit.
*/

`timescale 1ns/1ps

module flit_assembler (
  input  flow_deser_pkg::push_flit_t          push_flit,
  input  flow_deser_pkg::flit_id_t            flit_id,
  input  logic [flow_deser_pkg::deser_ratio-2:0][flow_deser_pkg::push_width-1:0]
                                              slices,
  output flow_deser_pkg::pop_flit_t           pop_flit
);

  // Index of the final slice of a word
  localparam flow_deser_pkg::flit_id_t last_index =
    flow_deser_pkg::flit_id_t'(flow_deser_pkg::deser_ratio - 1);

  // Slices in arrival order after zero-fill with the first flit in slot 0
  logic [flow_deser_pkg::deser_ratio-1:0][flow_deser_pkg::push_width-1:0] arrived;

  // Slices in their final bit positions within the pop word
  logic [flow_deser_pkg::deser_ratio-1:0][flow_deser_pkg::push_width-1:0] placed;

  // --------------------------------------------------
  // Slice selection in arrival order
  // --------------------------------------------------

  // Slots already passed hold stored data and the slot at the index takes the live flit
  // Later slots are zero because the word ended early
  always_comb begin
    for (int i = 0; i < flow_deser_pkg::deser_ratio - 1; i++) begin
      if (flow_deser_pkg::flit_id_t'(i) < flit_id) begin
        arrived[i] = slices[i];
      end else if (flow_deser_pkg::flit_id_t'(i) == flit_id) begin
        arrived[i] = push_flit.data;
      end else begin
        arrived[i] = '0;
      end
    end
    // The final slot has no register and only ever holds the live flit
    arrived[flow_deser_pkg::deser_ratio-1] = (flit_id == last_index) ? push_flit.data : '0;
  end

  // --------------------------------------------------
  // Slice placement
  // --------------------------------------------------

  // With msb-first order the first flit goes to the top slice and the
  // zero-filled tail ends up in the low bits
  always_comb begin
    for (int i = 0; i < flow_deser_pkg::deser_ratio; i++) begin
      if (flow_deser_pkg::deserialize_msb_first) begin
        placed[flow_deser_pkg::deser_ratio-1-i] = arrived[i];
      end else begin
        placed[i] = arrived[i];
      end
    end
  end

  // --------------------------------------------------
  // Pop word fields
  // --------------------------------------------------

  assign pop_flit.data = placed;
  assign pop_flit.last = push_flit.last;

  // Number of unfilled tail slices of a last word
  // Full words report zero
  assign pop_flit.dont_care_count = push_flit.last ? (last_index - flit_id) : '0;

  // Metadata is constant across a packet, so the live flit carries it
  assign pop_flit.metadata = push_flit.metadata;

endmodule

//--- source/flow_deserializer.sv
/*
  Top level of the packet flit deserializer.
  Accepts 8-bit flits with a last flag and metadata on the push side and
  delivers 32-bit words on the pop side, both with ready/valid and
  back-pressure. A word completes when four flits have arrived or when
  a flit carries last, and it is presented in the same cycle as that
  completing flit.
*/

`timescale 1ns/1ps

module flow_deserializer (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        push_valid,
  output logic                        push_ready,
  input  flow_deser_pkg::push_flit_t  push_flit,
  output logic                        pop_valid,
  input  logic                        pop_ready,
  output flow_deser_pkg::pop_flit_t   pop_flit
);

  // --------------------------------------------------
  // Internal connections
  // --------------------------------------------------

  // Slice of the word that the flit on the push side fills
  flow_deser_pkg::flit_id_t flit_id;

  // Per-slice capture strobes from the sequencer
  logic [flow_deser_pkg::deser_ratio-2:0] slice_load;

  // Slices already gathered for the current word
  logic [flow_deser_pkg::deser_ratio-2:0][flow_deser_pkg::push_width-1:0] slices;

  // --------------------------------------------------
  // Handshake control and slice index
  // --------------------------------------------------

  flit_sequencer u_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_last  (push_flit.last),
    .pop_ready  (pop_ready),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .flit_id    (flit_id),
    .slice_load (slice_load)
  );

  // --------------------------------------------------
  // Storage of the non-final slices
  // --------------------------------------------------

  slice_store u_store (
    .clk        (clk),
    .arst_n     (arst_n),
    .slice_load (slice_load),
    .slice_data (push_flit.data),
    .slices     (slices)
  );

  // --------------------------------------------------
  // Pop word assembly
  // --------------------------------------------------

  // Purely combinational, so a held push flit keeps the pop word stable
  flit_assembler u_assembler (
    .push_flit (push_flit),
    .flit_id   (flit_id),
    .slices    (slices),
    .pop_flit  (pop_flit)
  );

endmodule

//--- testbench/tb_clock_gen.sv
/*
  Clock and reset source for the deserializer testbench.
  Produces a free-running 4 ns clock and an active-low reset that is
  held for 16 clock cycles and released on a falling edge.
*/

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // Half of the 4 ns clock period
  localparam int half_period_ns = 2;

  // Number of rising edges seen with reset asserted
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // Release away from the rising edge so the first active edge is clean
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- testbench/tb_flow_deserializer.sv
/*
  Testbench for the packet flit deserializer.
  Sends random packets of 1 to 9 flits with random gaps while pop_ready
  is pulled low at random. A model queue holds the word expected for each
  accepted completing flit, and concurrent assertions on the rising edge
  compare the DUT against it and check the handshake rules.
*/

`timescale 1ns/1ps

module tb_flow_deserializer;

  localparam int num_packets  = 300;
  localparam int max_wait     = 1000;
  localparam int ratio        = flow_deser_pkg::deser_ratio;
  localparam int slice_bits   = flow_deser_pkg::push_width;

  logic                       clk;
  logic                       arst_n;
  logic                       push_valid;
  logic                       push_ready;
  flow_deser_pkg::push_flit_t push_flit;
  logic                       pop_valid;
  logic                       pop_ready;
  flow_deser_pkg::pop_flit_t  pop_flit;
  logic                       pop_fire;

  integer seed;

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------

  // Data of the flits accepted so far for the word being built
  logic [slice_bits-1:0]     part_data [0:ratio-1];
  int                        part_count;
  flow_deser_pkg::pop_flit_t model_q [$];
  flow_deser_pkg::pop_flit_t head_word;
  logic                      head_valid;
  flow_deser_pkg::pop_flit_t flit_at_edge;
  int                        expected_count;
  int                        pop_count;

  tb_clock_gen u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  flow_deserializer i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_flit  (push_flit),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_flit   (pop_flit)
  );

  assign pop_fire = pop_valid && pop_ready;

  task automatic report_mismatch(input string check, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[FAIL] %s expected %0h actual %0h", check, expected, actual);
    $display("Checks failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  // Builds the word the pop side should show once count flits are held
  // First flit sits in slot 0 of the arrival order, unused slots stay zero
  function automatic flow_deser_pkg::pop_flit_t expected_word(input int count,
                                                              input logic last,
                                                              input logic [2:0] meta);
    flow_deser_pkg::pop_flit_t word;
    int                        slot;
    int                        i;
    word = '0;
    for (i = 0; i < count; i++) begin
      slot = flow_deser_pkg::deserialize_msb_first ? ratio - 1 - i : i;
      word.data[slot*slice_bits +: slice_bits] = part_data[i];
    end
    word.last = last;
    word.dont_care_count = last ? flow_deser_pkg::flit_id_t'(ratio - count) : '0;
    word.metadata = meta;
    return word;
  endfunction

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  // Every input change happens on the falling edge
  // pop_ready is low about one cycle in three
  task automatic next_cycle();
    @(negedge clk);
    pop_ready = (({$random(seed)} % 3) != 0);
  endtask

  // Presents one flit and holds it until the DUT takes it
  task automatic send_flit(input flow_deser_pkg::push_flit_t flit);
    int                        waited;
    logic                      completes;
    flow_deser_pkg::pop_flit_t pending;
    waited = 0;
    push_valid = 1'b1;
    push_flit = flit;
    completes = flit.last || (part_count == ratio - 1);
    part_data[part_count] = flit.data;
    pending = expected_word(part_count + 1, flit.last, flit.metadata);
    // Handshake outputs settle well before the next rising edge
    #1;
    while (!push_ready && waited < max_wait) begin
      next_cycle();
      #1;
      waited++;
    end
    if (!push_ready) begin
      fail_run("push flit was not accepted within the timeout");
    end else begin
      if (completes) begin
        model_q.push_back(pending);
        head_word = model_q[0];
        head_valid = 1'b1;
        expected_count++;
        part_count = 0;
      end else begin
        part_count++;
      end
      next_cycle();
      push_valid = 1'b0;
    end
  endtask

  // One packet shares a metadata value, last marks its final flit
  task automatic send_packet();
    int                         length;
    int                         gap;
    int                         i;
    logic [2:0]                 meta;
    flow_deser_pkg::push_flit_t flit;
    length = 1 + int'({$random(seed)} % 9);
    meta = 3'($random(seed));
    for (i = 0; i < length; i++) begin
      flit.data = 8'($random(seed));
      flit.last = (i == length - 1);
      flit.metadata = meta;
      send_flit(flit);
      gap = (({$random(seed)} % 2) == 0) ? 0 : 1 + int'({$random(seed)} % 3);
      repeat (gap) next_cycle();
    end
  endtask

  // --------------------------------------------------
  // Pop side monitor
  // --------------------------------------------------

  // Inputs only move on the falling edge, so pop_fire is settled here
  always @(posedge clk) begin
    if (arst_n && pop_fire) begin
      pop_count = pop_count + 1;
      if (model_q.size() != 0) begin
        void'(model_q.pop_front());
      end
      head_valid = (model_q.size() != 0);
      if (head_valid) begin
        head_word = model_q[0];
      end
    end
    flit_at_edge = pop_flit;
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  reset_quiet: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |-> !pop_valid)
    else report_mismatch("reset_quiet", 64'd0, 64'($sampled(pop_valid)));

  reset_ready: assert property (@(posedge clk) $rose(arst_n) |-> push_ready)
    else report_mismatch("reset_ready", 64'd1, 64'($sampled(push_ready)));

  word_expected: assert property (@(posedge clk) disable iff (!arst_n) pop_fire |-> head_valid)
    else fail_run("a word was popped while the model expected none");

  full_word: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_fire && !head_word.last) |-> (pop_flit == head_word))
    else report_mismatch("full_word", 64'($sampled(head_word)), 64'($sampled(pop_flit)));

  short_tail: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_fire && head_word.last) |-> (pop_flit == head_word))
    else report_mismatch("short_tail", 64'($sampled(head_word)), 64'($sampled(pop_flit)));

  stall_push: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) |-> !push_ready)
    else report_mismatch("stall_push", 64'd0, 64'($sampled(push_ready)));

  stall_valid: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) |=> pop_valid)
    else report_mismatch("stall_valid", 64'd1, 64'($sampled(pop_valid)));

  // flit_at_edge still holds the word seen one edge earlier
  stall_word: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) |=> $stable(pop_flit))
    else report_mismatch("stall_word", 64'($sampled(flit_at_edge)), 64'($sampled(pop_flit)));

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    int waited;
    int p;
    seed = 32'h78c8;
    push_valid = 1'b0;
    push_flit = '0;
    pop_ready = 1'b0;
    part_count = 0;
    expected_count = 0;
    pop_count = 0;
    head_valid = 1'b0;
    head_word = '0;
    flit_at_edge = '0;
    waited = 0;
    while (arst_n !== 1'b1 && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      fail_run("reset was not released within the timeout");
    end else begin
      // Quiet cycle right after reset for the reset checks
      repeat (2) next_cycle();
      for (p = 0; p < num_packets; p++) begin
        send_packet();
      end
      waited = 0;
      while ((model_q.size() != 0 || pop_count != expected_count) && waited < max_wait) begin
        next_cycle();
        waited++;
      end
      if (model_q.size() != 0 || pop_count != expected_count) begin
        report_mismatch("completeness", 64'(expected_count), 64'(pop_count));
      end else begin
        $display("All checks passed");
        $finish;
      end
    end
  end

endmodule

//--- flist.f
source/flow_deser_pkg.sv
source/flit_sequencer.sv
source/slice_store.sv
source/flit_assembler.sv
source/flow_deserializer.sv
testbench/tb_clock_gen.sv
testbench/tb_flow_deserializer.sv

//--- Makefile
# Verilator build for the flit deserializer testbench

VERILATOR  ?= verilator
TOP        := tb_flow_deserializer
FILELIST   := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := All checks passed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# The run passes only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
